// ==== all.f ====
+incdir+rtl
rtl/vec_types_pkg.sv
rtl/vec_isa_pkg.sv
rtl/apb_vec_regs.sv
rtl/vector_ctrl.sv
rtl/vrf_bank.sv
rtl/lane_alu.sv
rtl/vector_unit_top.sv
test/tb_clock_gen.sv
test/vector_unit_tb.sv

// ==== rtl/apb_vec_regs.sv ====
`timescale 1ns/1ps
`include "vec_consts.svh"

module apb_vec_regs
   import vec_types_pkg::*;
   import vec_isa_pkg::*;
(
   input  logic        pclk,
   input  logic        rst,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  apb_addr_t   paddr,
   input  vec_elem_t   pwdata,
   output vec_elem_t   prdata,
   output logic        pready,
   output logic        pslverr,
   output logic        instr_start,
   output vec_instr_t  instr,
   output vec_elem_t   scalar,
   output elem_req_t   elem_req,
   input  logic        elem_ack,
   input  vec_elem_t   elem_rdata,
   input  logic        busy,
   input  vec_status_t status
);

   logic      acc;
   logic      is_instr;
   logic      is_status;
   logic      is_scalar;
   logic      is_sel;
   logic      is_data;
   logic      mapped;
   logic      err;
   vreg_idx_t sel_vreg;
   elem_idx_t sel_elem;

   assign acc = psel & penable;

   // offset decode
   assign is_instr  = (paddr == `VEC_OFS_INSTR);
   assign is_status = (paddr == `VEC_OFS_STATUS);
   assign is_scalar = (paddr == `VEC_OFS_SCALAR);
   assign is_sel    = (paddr == `VEC_OFS_ELEM_SEL);
   assign is_data   = (paddr == `VEC_OFS_ELEM_DATA);
   assign mapped    = is_instr | is_status | is_scalar | is_sel | is_data;

   // refused while an instruction runs
   assign err = !mapped
              | (busy & pwrite & (is_instr | is_scalar | is_data))
              | (busy & !pwrite & is_data);

   // element data waits for the controller, everything else is immediate
   assign pready  = acc & (err | !is_data | elem_ack);
   assign pslverr = acc & err;

   assign instr_start = acc & pwrite & is_instr & !err;
   assign instr       = vec_instr_t'(pwdata[$bits(vec_instr_t)-1:0]);

   // valid drops in the ack cycle so the request is not taken twice
   assign elem_req.valid = acc & is_data & !err & !elem_ack;
   assign elem_req.write = pwrite;
   assign elem_req.vreg  = sel_vreg;
   assign elem_req.elem  = sel_elem;
   assign elem_req.wdata = pwdata;

   always_ff @(posedge pclk)
   begin
      if (rst)
      begin
         sel_vreg <= '0;
         sel_elem <= '0;
      end
      else if (acc && pwrite && is_sel && !err)
      begin
         // element in the low bits, register just above
         sel_elem <= pwdata[$bits(elem_idx_t)-1:0];
         sel_vreg <= pwdata[$bits(elem_idx_t) +: $bits(vreg_idx_t)];
      end
   end

   always_ff @(posedge pclk)
   begin
      if (acc && pwrite && is_scalar && !err)
         scalar <= pwdata;
   end

   // read mux, INSTR reads back as zero
   always_comb
   begin
      prdata = '0;
      if (is_status)
         prdata = vec_elem_t'(status);
      else if (is_scalar)
         prdata = scalar;
      else if (is_sel)
         prdata = vec_elem_t'({sel_vreg, sel_elem});
      else if (is_data)
         prdata = elem_rdata;
   end

   // master must hold the transfer while we stretch pready
   a_apb_stable: assert property (@(posedge pclk) disable iff (rst)
      (psel && penable && !pready) |=> (psel && $stable(paddr) && $stable(pwrite)));

endmodule

// ==== rtl/lane_alu.sv ====
`timescale 1ns/1ps

module lane_alu
   import vec_types_pkg::*;
   import vec_isa_pkg::*;
(
   input  logic      pclk,
   input  vec_op_e   op,
   input  vec_elem_t a,
   input  vec_elem_t b,
   input  vec_elem_t scalar,
   output vec_elem_t res
);

   vec_elem_t res_next;

   // a is vs1, b is vs2, all results wrap
   always_comb
   begin
      case (op)
         VADD:
            res_next = a + b;
         VSUB:
            res_next = a - b;
         VAND:
            res_next = a & b;
         VOR:
            res_next = a | b;
         VXOR:
            res_next = a ^ b;
         // low half of the product
         VMUL:
            res_next = a * b;
         VADDX:
            res_next = a + scalar;
         VSPLAT:
            res_next = scalar;
         default:
            res_next = '0;
      endcase
   end

   always_ff @(posedge pclk)
   begin
      res <= res_next;
   end

endmodule

// ==== rtl/vec_consts.svh ====
`ifndef VEC_CONSTS_SVH
`define VEC_CONSTS_SVH

// unit geometry
`define VEC_LANES 4
`define VEC_REGS 8
`define VEC_ELEMS 16
`define VEC_ELEM_W 32

// rows each lane bank holds per register
`define VEC_ROWS (`VEC_ELEMS / `VEC_LANES)

// apb register window offsets
`define VEC_OFS_INSTR 8'h00
`define VEC_OFS_STATUS 8'h04
`define VEC_OFS_SCALAR 8'h08
`define VEC_OFS_ELEM_SEL 8'h10
`define VEC_OFS_ELEM_DATA 8'h14

`endif

// ==== rtl/vec_isa_pkg.sv ====
package vec_isa_pkg;

   import vec_types_pkg::*;

   // opcodes 8 to 15 are illegal
   typedef enum logic [3:0] {
      VADD   = 4'd0,
      VSUB   = 4'd1,
      VAND   = 4'd2,
      VOR    = 4'd3,
      VXOR   = 4'd4,
      VMUL   = 4'd5,
      VADDX  = 4'd6,
      VSPLAT = 4'd7
   } vec_op_e;

   // low 16 bits of the INSTR register, opcode in the lsbs
   typedef struct packed {
      logic [2:0] spare;
      vreg_idx_t  vs2;
      vreg_idx_t  vs1;
      vreg_idx_t  vd;
      logic [3:0] opcode;
   } vec_instr_t;

   typedef struct packed {
      logic [15:0] done_cnt;
      logic [13:0] rsvd;
      logic        illegal;
      logic        busy;
   } vec_status_t;

   typedef enum logic [2:0] {
      st_idle,
      st_issue,
      st_drain,
      st_elem_rd,
      st_elem_wr
   } ctrl_state_e;

   // single element access from the host
   typedef struct packed {
      logic      valid;
      logic      write;
      vreg_idx_t vreg;
      elem_idx_t elem;
      vec_elem_t wdata;
   } elem_req_t;

endpackage

// ==== rtl/vec_types_pkg.sv ====
`include "vec_consts.svh"

package vec_types_pkg;

   // data side widths
   typedef logic [`VEC_ELEM_W-1:0] vec_elem_t;
   typedef logic [$clog2(`VEC_REGS)-1:0] vreg_idx_t;
   typedef logic [$clog2(`VEC_ROWS)-1:0] vrow_t;
   typedef logic [$clog2(`VEC_ELEMS)-1:0] elem_idx_t;
   typedef logic [7:0] apb_addr_t;

   // one bit or one element per lane
   typedef logic [`VEC_LANES-1:0] lane_mask_t;
   typedef vec_elem_t [`VEC_LANES-1:0] lane_data_t;

   // read request, same row from two registers in every lane
   typedef struct packed {
      vreg_idx_t reg_a;
      vreg_idx_t reg_b;
      vrow_t     row;
   } lane_rd_t;

   // write request with a per-lane enable
   typedef struct packed {
      lane_mask_t en;
      vreg_idx_t  vreg;
      vrow_t      row;
      lane_data_t data;
   } lane_wr_t;

endpackage

// ==== rtl/vector_ctrl.sv ====
`timescale 1ns/1ps
`include "vec_consts.svh"

module vector_ctrl
   import vec_types_pkg::*;
   import vec_isa_pkg::*;
(
   input  logic        pclk,
   input  logic        rst,
   input  logic        instr_start,
   input  vec_instr_t  instr,
   input  vec_elem_t   scalar,
   input  elem_req_t   elem_req,
   output logic        elem_ack,
   output vec_elem_t   elem_rdata,
   output logic        busy,
   output vec_status_t status,
   output lane_rd_t    lane_rd,
   output vec_op_e     alu_op,
   output vec_elem_t   alu_scalar,
   input  lane_data_t  rd_data,
   input  lane_data_t  alu_res,
   output lane_wr_t    lane_wr
);

   localparam int    LANE_W   = $clog2(`VEC_LANES);
   localparam vrow_t LAST_ROW = vrow_t'(`VEC_ROWS - 1);

   ctrl_state_e       state;
   vec_instr_t        cur_instr;
   vrow_t             issue_row;
   logic [1:0]        wb_vld;
   vrow_t [1:0]       wb_row;
   vreg_idx_t [1:0]   wb_vd;
   logic              illegal;
   logic [15:0]       done_cnt;
   logic              rd_ack;
   vec_elem_t         rd_hold;
   logic              op_legal;
   logic [LANE_W-1:0] elem_lane;
   vrow_t             elem_row;

   assign op_legal = (instr.opcode <= 4'(VSPLAT));

   // element e sits in lane e mod lanes, row e div lanes
   assign elem_lane = elem_req.elem[LANE_W-1:0];
   assign elem_row  = vrow_t'(elem_req.elem >> LANE_W);

   always_ff @(posedge pclk)
   begin
      if (rst)
      begin
         state     <= st_idle;
         issue_row <= '0;
         wb_vld    <= '0;
         illegal   <= 1'b0;
         done_cnt  <= '0;
         rd_ack    <= 1'b0;
      end
      else
      begin
         rd_ack <= 1'b0;
         wb_vld <= {wb_vld[0], state == st_issue};
         case (state)
            st_idle:
               if (instr_start)
               begin
                  illegal   <= !op_legal;
                  issue_row <= '0;
                  if (op_legal)
                     state <= st_issue;
               end
               else if (elem_req.valid)
                  state <= elem_req.write ? st_elem_wr : st_elem_rd;
            st_issue:
            begin
               issue_row <= issue_row + 1'b1;
               if (issue_row == LAST_ROW)
                  state <= st_drain;
            end
            // done once the last row lands
            st_drain:
               if (wb_vld[1] && wb_row[1] == LAST_ROW)
               begin
                  state    <= st_idle;
                  done_cnt <= done_cnt + 1'b1;
               end
            st_elem_rd:
            begin
               rd_ack <= 1'b1;
               state  <= st_idle;
            end
            default:
               state <= st_idle;
         endcase
      end
   end

   // two-deep write-back shift matching bank read plus alu register
   always_ff @(posedge pclk)
   begin
      if (state == st_idle && instr_start && op_legal)
         cur_instr <= instr;
      wb_row <= {wb_row[0], issue_row};
      wb_vd  <= {wb_vd[0], cur_instr.vd};
      if (state == st_elem_rd)
         rd_hold <= rd_data[elem_lane];
   end

   assign busy       = (state == st_issue) || (state == st_drain);
   assign elem_ack   = (state == st_elem_wr) || rd_ack;
   assign elem_rdata = rd_hold;
   assign alu_op     = vec_op_e'(cur_instr.opcode);
   assign alu_scalar = scalar;

   always_comb
   begin
      status          = '0;
      status.busy     = busy;
      status.illegal  = illegal;
      status.done_cnt = done_cnt;
   end

   // bank follows the selected element outside row issue
   always_comb
   begin
      if (state == st_issue)
      begin
         lane_rd.reg_a = cur_instr.vs1;
         lane_rd.reg_b = cur_instr.vs2;
         lane_rd.row   = issue_row;
      end
      else
      begin
         lane_rd.reg_a = elem_req.vreg;
         lane_rd.reg_b = elem_req.vreg;
         lane_rd.row   = elem_row;
      end
   end

   always_comb
   begin
      lane_wr.en   = '0;
      lane_wr.vreg = wb_vd[1];
      lane_wr.row  = wb_row[1];
      lane_wr.data = alu_res;
      if (state == st_elem_wr)
      begin
         // host write touches one lane only
         lane_wr.en[elem_lane] = 1'b1;
         lane_wr.vreg          = elem_req.vreg;
         lane_wr.row           = elem_row;
         lane_wr.data          = {`VEC_LANES{elem_req.wdata}};
      end
      else if (wb_vld[1])
         lane_wr.en = '1;
   end

   // element traffic only while no instruction runs
   a_no_elem_busy: assert property (@(posedge pclk) disable iff (rst)
      !((elem_req.valid || elem_ack) && busy));

   a_idle_no_wr: assert property (@(posedge pclk) disable iff (rst)
      (state == st_idle) |-> (lane_wr.en == '0));

endmodule

// ==== rtl/vector_unit_top.sv ====
`timescale 1ns/1ps
`include "vec_consts.svh"

module vector_unit_top
   import vec_types_pkg::*;
   import vec_isa_pkg::*;
(
   input  logic      pclk,
   input  logic      rst,
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_addr_t paddr,
   input  vec_elem_t pwdata,
   output vec_elem_t prdata,
   output logic      pready,
   output logic      pslverr
);

   logic        instr_start;
   vec_instr_t  instr;
   vec_elem_t   scalar;
   elem_req_t   elem_req;
   logic        elem_ack;
   vec_elem_t   elem_rdata;
   logic        busy;
   vec_status_t status;
   lane_rd_t    lane_rd;
   lane_wr_t    lane_wr;
   vec_op_e     alu_op;
   vec_elem_t   alu_scalar;
   lane_data_t  rd_data;
   lane_data_t  alu_res;

   apb_vec_regs u_apb_vec_regs (
      .pclk        (pclk),
      .rst         (rst),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .instr_start (instr_start),
      .instr       (instr),
      .scalar      (scalar),
      .elem_req    (elem_req),
      .elem_ack    (elem_ack),
      .elem_rdata  (elem_rdata),
      .busy        (busy),
      .status      (status)
   );

   vector_ctrl u_vector_ctrl (
      .pclk        (pclk),
      .rst         (rst),
      .instr_start (instr_start),
      .instr       (instr),
      .scalar      (scalar),
      .elem_req    (elem_req),
      .elem_ack    (elem_ack),
      .elem_rdata  (elem_rdata),
      .busy        (busy),
      .status      (status),
      .lane_rd     (lane_rd),
      .alu_op      (alu_op),
      .alu_scalar  (alu_scalar),
      .rd_data     (rd_data),
      .alu_res     (alu_res),
      .lane_wr     (lane_wr)
   );

   // one bank and one alu per lane
   for (genvar l = 0; l < `VEC_LANES; l++)
   begin : g_lane
      vec_elem_t lane_rd_b;

      vrf_bank u_vrf_bank (
         .pclk    (pclk),
         .rd      (lane_rd),
         .wr_en   (lane_wr.en[l]),
         .wr_reg  (lane_wr.vreg),
         .wr_row  (lane_wr.row),
         .wr_data (lane_wr.data[l]),
         .rd_a    (rd_data[l]),
         .rd_b    (lane_rd_b)
      );

      lane_alu u_lane_alu (
         .pclk   (pclk),
         .op     (alu_op),
         .a      (rd_data[l]),
         .b      (lane_rd_b),
         .scalar (alu_scalar),
         .res    (alu_res[l])
      );
   end

endmodule

// ==== rtl/vrf_bank.sv ====
`timescale 1ns/1ps
`include "vec_consts.svh"

module vrf_bank
   import vec_types_pkg::*;
(
   input  logic      pclk,
   input  lane_rd_t  rd,
   input  logic      wr_en,
   input  vreg_idx_t wr_reg,
   input  vrow_t     wr_row,
   input  vec_elem_t wr_data,
   output vec_elem_t rd_a,
   output vec_elem_t rd_b
);

   // this lane's rows of every register
   vec_elem_t mem [`VEC_REGS][`VEC_ROWS];

   always_ff @(posedge pclk)
   begin
      if (wr_en)
         mem[wr_reg][wr_row] <= wr_data;
   end

   // registered reads, a same-cycle write is seen next cycle
   always_ff @(posedge pclk)
   begin
      rd_a <= mem[rd.reg_a][rd.row];
      rd_b <= mem[rd.reg_b][rd.row];
   end

   a_wr_known: assert property (@(posedge pclk)
      wr_en |-> !$isunknown(wr_data));

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic rst
);

   // 8 ns period
   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;
   end

   // reset held for 8 rising edges, released just after the edge
   initial
   begin
      rst = 1'b1;
      repeat (8)
         @(posedge clk);
      #1 rst = 1'b0;
   end

endmodule

// ==== test/vector_trace.txt ====
# columns: test dir(W/R) offset data pslverr, reads add: expected kind(elem/status)
# offset and data in hex, ELEM_SEL data is vreg*16+elem, INSTR is vs2.vs1.vd.opcode
reset_status R 04 00000000 0 00000000 status
fill_scalar W 08 00000100 0
fill_v1 W 00 00000017 0
fill_scalar W 08 00000200 0
fill_v2 W 00 00000027 0
fill_status R 04 00000000 0 00020000 status
elem_v1_e0 W 10 00000010 0
elem_v1_e0 W 14 00000007 0
elem_v1_e0 R 14 00000000 0 00000007 elem
elem_v1_e5 W 10 00000015 0
elem_v1_e5 W 14 12345678 0
elem_v1_e5 R 14 00000000 0 12345678 elem
elem_v1_e10 W 10 0000001a 0
elem_v1_e10 W 14 ffffffff 0
elem_v1_e10 R 14 00000000 0 ffffffff elem
elem_v1_e15 W 10 0000001f 0
elem_v1_e15 W 14 80000001 0
elem_v1_e15 R 14 00000000 0 80000001 elem
elem_v2_e0 W 10 00000020 0
elem_v2_e0 W 14 00000005 0
elem_v2_e0 R 14 00000000 0 00000005 elem
elem_v2_e5 W 10 00000025 0
elem_v2_e5 W 14 0f0f0f0f 0
elem_v2_e5 R 14 00000000 0 0f0f0f0f elem
elem_v2_e10 W 10 0000002a 0
elem_v2_e10 W 14 00000002 0
elem_v2_e10 R 14 00000000 0 00000002 elem
elem_v2_e15 W 10 0000002f 0
elem_v2_e15 W 14 80000003 0
elem_v2_e15 R 14 00000000 0 80000003 elem
elem_v1_e1 W 10 00000011 0
elem_v1_e1 R 14 00000000 0 00000100 elem
op_vadd W 00 000008b0 0
op_vadd R 04 00000000 0 00030000 status
op_vadd_e0 W 10 00000030 0
op_vadd_e0 R 14 00000000 0 0000000c elem
op_vadd_e10 W 10 0000003a 0
op_vadd_e10 R 14 00000000 0 00000001 elem
op_vsub W 00 000008b1 0
op_vsub_e5 W 10 00000035 0
op_vsub_e5 R 14 00000000 0 03254769 elem
op_vsub_e15 W 10 0000003f 0
op_vsub_e15 R 14 00000000 0 fffffffe elem
op_vand W 00 000008b2 0
op_vand_e0 W 10 00000030 0
op_vand_e0 R 14 00000000 0 00000005 elem
op_vand_e10 W 10 0000003a 0
op_vand_e10 R 14 00000000 0 00000002 elem
op_vor W 00 000008b3 0
op_vor_e5 W 10 00000035 0
op_vor_e5 R 14 00000000 0 1f3f5f7f elem
op_vor_e15 W 10 0000003f 0
op_vor_e15 R 14 00000000 0 80000003 elem
op_vxor W 00 000008b4 0
op_vxor_e0 W 10 00000030 0
op_vxor_e0 R 14 00000000 0 00000002 elem
op_vxor_e10 W 10 0000003a 0
op_vxor_e10 R 14 00000000 0 fffffffd elem
op_vmul W 00 000008b5 0
op_vmul_e10 W 10 0000003a 0
op_vmul_e10 R 14 00000000 0 fffffffe elem
op_vmul_e15 W 10 0000003f 0
op_vmul_e15 R 14 00000000 0 00000003 elem
op_vaddx W 08 00000010 0
op_vaddx W 00 000008b6 0
op_vaddx_e5 W 10 00000035 0
op_vaddx_e5 R 14 00000000 0 12345688 elem
op_vaddx_e15 W 10 0000003f 0
op_vaddx_e15 R 14 00000000 0 80000011 elem
op_vsplat W 08 deadbeef 0
op_vsplat W 00 000008b7 0
op_vsplat_e0 W 10 00000030 0
op_vsplat_e0 R 14 00000000 0 deadbeef elem
op_vsplat_e15 W 10 0000003f 0
op_vsplat_e15 R 14 00000000 0 deadbeef elem
op_vsplat R 04 00000000 0 000a0000 status
busy_instr W 00 000008c0 0
busy_instr W 00 000008c0 1
busy_v4_e0 W 10 00000040 0
busy_v4_e0 R 14 00000000 0 0000000c elem
busy_status R 04 00000000 0 000b0000 status
same_reg W 00 00000891 0
same_reg_e0 W 10 00000010 0
same_reg_e0 R 14 00000000 0 00000002 elem
same_reg_e5 W 10 00000015 0
same_reg_e5 R 14 00000000 0 03254769 elem
same_reg_e10 W 10 0000001a 0
same_reg_e10 R 14 00000000 0 fffffffd elem
same_reg_e15 W 10 0000001f 0
same_reg_e15 R 14 00000000 0 fffffffe elem
same_reg_e1 W 10 00000011 0
same_reg_e1 R 14 00000000 0 ffffff00 elem
same_reg R 04 00000000 0 000c0000 status
illegal_op W 00 00000029 0
illegal_op R 04 00000000 0 000c0002 status
illegal_v2_e0 W 10 00000020 0
illegal_v2_e0 R 14 00000000 0 00000005 elem
unmapped_wr W 0c 00000000 1
unmapped_rd R 18 00000000 1 00000000 elem
clear_illegal W 00 00000057 0
clear_illegal R 04 00000000 0 000d0000 status

// ==== test/vector_unit_tb.sv ====
`timescale 1ns/1ps
`include "vec_consts.svh"

module vector_unit_tb
   import vec_types_pkg::*;
   import vec_isa_pkg::*;
();

   logic      clk;
   logic      rst;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   vec_elem_t pwdata;
   vec_elem_t prdata;
   logic      pready;
   logic      pslverr;

   // one entry per trace line
   string     step_name[$];
   logic      step_wr[$];
   apb_addr_t step_addr[$];
   vec_elem_t step_data[$];
   logic      step_slv[$];
   vec_elem_t step_exp[$];
   string     step_kind[$];

   int          elem_errs = 0;
   int          status_errs = 0;
   int          slverr_errs = 0;
   int          ready_errs = 0;
   int          other_errs = 0;
   int unsigned cycles = 0;
   int unsigned cycle_limit = 0;
   logic        trace_ok;

   tb_clock_gen u_tb_clock_gen (
      .clk (clk),
      .rst (rst)
   );

   vector_unit_top u_vector_unit_top (
      .pclk    (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   // hang guard with a limit set once the trace length is known
   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycle_limit != 0 && cycles > cycle_limit)
      begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Test failed");
         $finish;
      end
   end

   task automatic load_trace(output logic ok);
      int          fd;
      int          code;
      int          slv_v;
      logic        bad;
      string       tok;
      string       dir;
      string       kind;
      string       rest;
      logic [31:0] addr_v;
      logic [31:0] data_v;
      logic [31:0] exp_v;
      begin
         ok  = 1'b0;
         bad = 1'b0;
         fd  = $fopen("test/vector_trace.txt", "r");
         if (fd == 0)
            $display("cannot open test/vector_trace.txt");
         else
         begin
            while (!$feof(fd))
            begin
               code = $fscanf(fd, "%s", tok);
               if (code != 1)
                  break;
               // comment lines start with #
               if (tok.getc(0) == "#")
               begin
                  code = $fgets(rest, fd);
                  continue;
               end
               code  = $fscanf(fd, "%s %h %h %d", dir, addr_v, data_v, slv_v);
               kind  = "none";
               exp_v = '0;
               if (code != 4)
                  bad = 1'b1;
               if (dir == "R")
               begin
                  code = $fscanf(fd, "%h %s", exp_v, kind);
                  if (code != 2)
                     bad = 1'b1;
               end
               step_name.push_back(tok);
               step_wr.push_back(dir == "W");
               step_addr.push_back(apb_addr_t'(addr_v));
               step_data.push_back(data_v);
               step_slv.push_back(slv_v != 0);
               step_exp.push_back(exp_v);
               step_kind.push_back(kind);
            end
            $fclose(fd);
            if (bad)
               $display("trace line with missing columns near step %s", tok);
            ok          = !bad && (step_name.size() > 0);
            cycle_limit = step_name.size() * 40 + 200;
         end
      end
   endtask

   // starts just after a rising edge and returns just after the completing edge
   task automatic apb_xfer(input logic wr, input apb_addr_t addr, input vec_elem_t data,
                           output vec_elem_t rdata, output logic err, output int waits);
      begin
         psel    = 1'b1;
         penable = 1'b0;
         pwrite  = wr;
         paddr   = addr;
         pwdata  = data;
         waits   = 0;
         @(posedge clk);
         #1 penable = 1'b1;
         @(negedge clk);
         while (pready !== 1'b1)
         begin
            waits++;
            @(negedge clk);
         end
         rdata = prdata;
         err   = pslverr;
         @(posedge clk);
         #1;
         psel    = 1'b0;
         penable = 1'b0;
      end
   endtask

   task automatic wait_not_busy();
      vec_elem_t   rdata;
      vec_status_t st;
      logic        err;
      int          waits;
      begin
         do
         begin
            apb_xfer(1'b0, `VEC_OFS_STATUS, '0, rdata, err, waits);
            st = vec_status_t'(rdata);
         end
         while (st.busy !== 1'b0);
      end
   endtask

   // access cycles with pready low, by register and direction
   function automatic int access_delay(input logic wr, input apb_addr_t addr,
                                       input logic slv);
      begin
         if (slv || addr != `VEC_OFS_ELEM_DATA)
            access_delay = 0;
         else if (wr)
            access_delay = 1;
         else
            access_delay = 2;
      end
   endfunction

   task automatic check_elem(input string name, input vec_elem_t exp, input vec_elem_t act);
      begin
         if (act !== exp)
         begin
            $display("Fail %s: expected %h actual %h", name, exp, act);
            elem_errs++;
         end
      end
   endtask

   task automatic check_status(input string name, input vec_status_t exp,
                               input vec_status_t act);
      begin
         if (act !== exp)
         begin
            $display("Fail %s: expected %h actual %h (count %0d illegal %b busy %b)",
                     name, exp, act, act.done_cnt, act.illegal, act.busy);
            status_errs++;
         end
      end
   endtask

   task automatic check_slverr(input string name, input logic exp, input logic act);
      begin
         if (act !== exp)
         begin
            $display("Fail %s: expected pslverr %b actual %b", name, exp, act);
            slverr_errs++;
         end
      end
   endtask

   task automatic check_delay(input string name, input int exp, input int act);
      begin
         if (act != exp)
         begin
            $display("Fail %s: expected pready delay %0d actual %0d", name, exp, act);
            ready_errs++;
         end
      end
   endtask

   task automatic run_step(input int i);
      vec_elem_t rdata;
      logic      err;
      int        waits;
      begin
         // instruction writes go straight out so the busy conflict shows
         if (!(step_wr[i] && step_addr[i] == `VEC_OFS_INSTR))
            wait_not_busy();
         apb_xfer(step_wr[i], step_addr[i], step_data[i], rdata, err, waits);
         check_slverr(step_name[i], step_slv[i], err);
         check_delay(step_name[i], access_delay(step_wr[i], step_addr[i], step_slv[i]),
                     waits);
         if (!step_wr[i] && !step_slv[i])
         begin
            if (step_kind[i] == "elem")
               check_elem(step_name[i], step_exp[i], rdata);
            else if (step_kind[i] == "status")
               check_status(step_name[i], vec_status_t'(step_exp[i]), vec_status_t'(rdata));
            else
            begin
               $display("step %s has an unknown result kind %s", step_name[i], step_kind[i]);
               other_errs++;
            end
         end
      end
   endtask

   initial
   begin
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      load_trace(trace_ok);
      if (!trace_ok)
      begin
         $display("no usable stimulus in the trace file");
         $display("Test failed");
         $finish;
      end
      else
      begin
         wait (rst === 1'b0);
         @(posedge clk);
         #1;
         for (int i = 0; i < step_name.size(); i++)
            run_step(i);
         $display("errors: elem %0d, status %0d, pslverr %0d, pready %0d, other %0d",
                  elem_errs, status_errs, slverr_errs, ready_errs, other_errs);
         if (elem_errs + status_errs + slverr_errs + ready_errs + other_errs == 0)
            $display("Test completed successfully");
         else
            $display("Test failed");
         $finish;
      end
   end

endmodule
